// File: design/lsu_pkg.sv
package lsu_pkg;

    // data path width of the core
    parameter int XLEN = 64;

    // byte lanes in one data word
    parameter int XBYTES = XLEN / 8;

    // byte offset bits inside a word
    parameter int OFFSET_BITS = $clog2(XBYTES);

    // access size, encoded as log2 of the byte count
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } access_size_t;

    // load width codes
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_LWU = 3'b110;

    // store width codes
    // same low codes as the loads, bit 2 never set
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;
    localparam logic [2:0] F3_SD  = 3'b011;

endpackage

// File: design/lsu_decode.sv
module lsu_decode
    import lsu_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                      we,
    input  logic [2:0]                funct3,
    input  logic [ADDR_WIDTH+2:0]     addr,
    input  logic [XLEN-1:0]           wdata,
    output access_size_t              size,
    output logic                      is_unsigned,
    output logic [OFFSET_BITS-1:0]    offset,
    output logic [ADDR_WIDTH-1:0]     word_index,
    output logic [XBYTES-1:0]         byte_mask,
    output logic [XLEN-1:0]           lane_wdata,
    output logic                      fault_now
);

    logic               illegal;
    logic               misaligned;
    logic [XBYTES-1:0]  size_mask;

    // byte address splits into word index and lane offset
    assign offset     = addr[OFFSET_BITS-1:0];
    assign word_index = addr[ADDR_WIDTH+2:OFFSET_BITS];

    // width code to size and sign
    always_comb begin
        size        = SIZE_B;
        is_unsigned = 1'b0;
        illegal     = 1'b0;
        if (we) begin
            case (funct3)
                F3_SB:   size = SIZE_B;
                F3_SH:   size = SIZE_H;
                F3_SW:   size = SIZE_W;
                F3_SD:   size = SIZE_D;
                // any code with bit 2 set
                default: illegal = 1'b1;
            endcase
        end else begin
            case (funct3)
                F3_LB:   size = SIZE_B;
                F3_LH:   size = SIZE_H;
                F3_LW:   size = SIZE_W;
                F3_LD:   size = SIZE_D;
                F3_LBU: begin
                    size        = SIZE_B;
                    is_unsigned = 1'b1;
                end
                F3_LHU: begin
                    size        = SIZE_H;
                    is_unsigned = 1'b1;
                end
                F3_LWU: begin
                    size        = SIZE_W;
                    is_unsigned = 1'b1;
                end
                // 111 has no load
                default: illegal = 1'b1;
            endcase
        end
    end

    // alignment check, mask and lane placement per size
    always_comb begin
        case (size)
            SIZE_B: begin
                misaligned = 1'b0;
                size_mask  = 8'h01;
                lane_wdata = {8{wdata[7:0]}};
            end
            SIZE_H: begin
                misaligned = offset[0];
                size_mask  = 8'h03;
                lane_wdata = {4{wdata[15:0]}};
            end
            SIZE_W: begin
                misaligned = |offset[1:0];
                size_mask  = 8'h0f;
                lane_wdata = {2{wdata[31:0]}};
            end
            default: begin
                misaligned = |offset;
                size_mask  = 8'hff;
                lane_wdata = wdata;
            end
        endcase
    end

    // mask lands on the addressed lanes
    assign byte_mask = size_mask << offset;

    // rejected request, ram suppresses it
    assign fault_now = illegal | misaligned;

endmodule

// File: design/lsu_ram.sv
module lsu_ram
    import lsu_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      req,
    input  logic                      we,
    input  logic                      fault_now,
    input  logic [ADDR_WIDTH-1:0]     word_index,
    input  logic [XBYTES-1:0]         byte_mask,
    input  logic [XLEN-1:0]           lane_wdata,
    input  access_size_t              size,
    input  logic                      is_unsigned,
    input  logic [OFFSET_BITS-1:0]    offset,
    output logic [XLEN-1:0]           rword,
    output logic                      load_valid,
    output logic                      fault,
    output access_size_t              size_q,
    output logic                      unsigned_q,
    output logic [OFFSET_BITS-1:0]    offset_q
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [XLEN-1:0] mem [DEPTH];

    logic wr_en;
    logic rd_en;

    // faulted requests touch nothing
    assign wr_en = req & we & ~fault_now;
    assign rd_en = req & ~we & ~fault_now;

    // byte-enable write, new data visible to the next read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < XBYTES; i++) begin
                if (byte_mask[i]) begin
                    mem[word_index][8*i +: 8] <= lane_wdata[8*i +: 8];
                end
            end
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rword <= mem[word_index];
        end
    end

    // load fields follow the read word by one cycle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            size_q     <= size;
            unsigned_q <= is_unsigned;
            offset_q   <= offset;
        end
    end

    // one-cycle pulses for load data and rejects
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_valid <= 1'b0;
            fault      <= 1'b0;
        end else begin
            load_valid <= rd_en;
            fault      <= req & fault_now;
        end
    end

endmodule

// File: design/lsu_result.sv
module lsu_result
    import lsu_pkg::*;
(
    input  logic [XLEN-1:0]           rword,
    input  access_size_t              size_q,
    input  logic                      unsigned_q,
    input  logic [OFFSET_BITS-1:0]    offset_q,
    output logic [XLEN-1:0]           rdata
);

    logic [XLEN-1:0] shifted;
    logic            sext;

    // addressed byte moves down to lane 0
    assign shifted = rword >> {offset_q, 3'b000};

    // signed loads copy the top kept bit
    assign sext = ~unsigned_q;

    // keep the access bytes, fill the rest
    always_comb begin
        case (size_q)
            SIZE_B: begin
                rdata = {{(XLEN-8){sext & shifted[7]}}, shifted[7:0]};
            end
            SIZE_H: begin
                rdata = {{(XLEN-16){sext & shifted[15]}}, shifted[15:0]};
            end
            SIZE_W: begin
                rdata = {{(XLEN-32){sext & shifted[31]}}, shifted[31:0]};
            end
            default: begin
                // full word, offset is always zero here
                rdata = shifted;
            end
        endcase
    end

endmodule

// File: design/lsu_top.sv
module lsu_top
    import lsu_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      req,
    input  logic                      we,
    input  logic [2:0]                funct3,
    input  logic [ADDR_WIDTH+2:0]     addr,
    input  logic [XLEN-1:0]           wdata,
    output logic                      rvalid,
    output logic [XLEN-1:0]           rdata,
    output logic                      fault
);

    // decode to ram
    access_size_t               size;
    logic                       is_unsigned;
    logic [OFFSET_BITS-1:0]     offset;
    logic [ADDR_WIDTH-1:0]      word_index;
    logic [XBYTES-1:0]          byte_mask;
    logic [XLEN-1:0]            lane_wdata;
    logic                       fault_now;

    // ram to result
    logic [XLEN-1:0]            rword;
    access_size_t               size_q;
    logic                       unsigned_q;
    logic [OFFSET_BITS-1:0]     offset_q;

    lsu_decode #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_decode (
        .we          (we),
        .funct3      (funct3),
        .addr        (addr),
        .wdata       (wdata),
        .size        (size),
        .is_unsigned (is_unsigned),
        .offset      (offset),
        .word_index  (word_index),
        .byte_mask   (byte_mask),
        .lane_wdata  (lane_wdata),
        .fault_now   (fault_now)
    );

    lsu_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ram (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .we          (we),
        .fault_now   (fault_now),
        .word_index  (word_index),
        .byte_mask   (byte_mask),
        .lane_wdata  (lane_wdata),
        .size        (size),
        .is_unsigned (is_unsigned),
        .offset      (offset),
        .rword       (rword),
        .load_valid  (rvalid),
        .fault       (fault),
        .size_q      (size_q),
        .unsigned_q  (unsigned_q),
        .offset_q    (offset_q)
    );

    lsu_result u_result (
        .rword       (rword),
        .size_q      (size_q),
        .unsigned_q  (unsigned_q),
        .offset_q    (offset_q),
        .rdata       (rdata)
    );

endmodule

// File: verification/lsu_tb.sv
module lsu_tb
    import lsu_pkg::*;
;

    localparam int AW   = 8;
    localparam int BA_W = AW + 3;

    // operation counts per test for the watchdog
    localparam int DIRECTED_OPS = 85;
    localparam int FILL_OPS     = 8;
    localparam int RANDOM_OPS   = 400;
    localparam int TOTAL_OPS    = DIRECTED_OPS + FILL_OPS + RANDOM_OPS;

    logic            clk;
    logic            arst_n;
    logic            req;
    logic            we;
    logic [2:0]      funct3;
    logic [BA_W-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            rvalid;
    logic [XLEN-1:0] rdata;
    logic            fault;

    // shadow copy of the ram with one entry per byte address
    logic [7:0] shadow [2**BA_W];

    // expectation for the request being driven and for the one in flight
    logic            next_valid;
    logic            next_fault;
    logic [XLEN-1:0] next_rdata;
    logic            exp_valid;
    logic            exp_fault;
    logic [XLEN-1:0] exp_rdata;

    logic [15:0] lfsr = 16'd4124;
    int          err_count  = 0;
    int          errs_start = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    lsu_top dut_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .we     (we),
        .funct3 (funct3),
        .addr   (addr),
        .wdata  (wdata),
        .rvalid (rvalid),
        .rdata  (rdata),
        .fault  (fault)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // results show up one edge after the request
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_valid <= 1'b0;
            exp_fault <= 1'b0;
            exp_rdata <= '0;
        end else begin
            exp_valid <= next_valid;
            exp_fault <= next_fault;
            exp_rdata <= next_rdata;
        end
    end

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] want);
        err_count++;
        $display("ERR @%0t: %s got %h expected %h", $time, what, got, want);
    endtask

    // outputs are stable at the falling edge
    valid_check: assert property (@(negedge clk) rvalid == exp_valid)
        else report_mismatch("rvalid", 64'(rvalid), 64'(exp_valid));
    fault_check: assert property (@(negedge clk) fault == exp_fault)
        else report_mismatch("fault", 64'(fault), 64'(exp_fault));
    rdata_check: assert property (@(negedge clk) !exp_valid || rdata == exp_rdata)
        else report_mismatch("rdata", rdata, exp_rdata);

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // illegal code or offset not a multiple of the size
    function automatic logic access_fault(input logic wr, input logic [2:0] f3,
                                          input logic [2:0] off);
        int nbytes;
        if (wr && f3[2]) begin
            return 1'b1;
        end
        if (!wr && f3 == 3'b111) begin
            return 1'b1;
        end
        nbytes = 1 << f3[1:0];
        return (int'(off) % nbytes) != 0;
    endfunction

    // gather bytes little endian and extend per funct3 bit 2
    function automatic logic [63:0] expected_load(input logic [2:0] f3,
                                                  input logic [BA_W-1:0] a);
        int          nbytes;
        logic [63:0] val;
        logic        sign;
        nbytes = 1 << f3[1:0];
        val    = '0;
        for (int i = 0; i < nbytes; i++) begin
            val[8*i +: 8] = shadow[a + BA_W'(i)];
        end
        sign = !f3[2] && val[8*nbytes-1];
        for (int b = 8 * nbytes; b < 64; b++) begin
            val[b] = sign;
        end
        return val;
    endfunction

    // one request per call with the shadow updated as the ram will be
    task automatic issue(input logic wr, input logic [2:0] f3,
                         input logic [BA_W-1:0] a, input logic [63:0] d);
        logic flt;
        int   nbytes;
        flt    = access_fault(wr, f3, a[2:0]);
        nbytes = 1 << f3[1:0];
        @(negedge clk);
        req        = 1'b1;
        we         = wr;
        funct3     = f3;
        addr       = a;
        wdata      = d;
        next_fault = flt;
        next_valid = !wr && !flt;
        next_rdata = '0;
        if (!flt && wr) begin
            for (int i = 0; i < nbytes; i++) begin
                shadow[a + BA_W'(i)] = d[8*i +: 8];
            end
        end else if (!flt) begin
            next_rdata = expected_load(f3, a);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            req        = 1'b0;
            next_valid = 1'b0;
            next_fault = 1'b0;
        end
    endtask

    // every load code at every aligned offset of one word
    task automatic load_sweep(input logic [BA_W-1:0] base);
        logic [2:0] f3;
        int         nb;
        for (int c = 0; c < 7; c++) begin
            f3 = 3'(c);
            nb = 1 << f3[1:0];
            for (int off = 0; off < 8; off += nb) begin
                issue(1'b0, f3, base + BA_W'(off), 64'd0);
            end
        end
    endtask

    task automatic random_traffic(input int count);
        logic            wr;
        logic [2:0]      f3;
        logic [BA_W-1:0] a;
        logic            align;
        // known contents in the 8-word window first
        for (int w = 0; w < FILL_OPS; w++) begin
            issue(1'b1, F3_SD, BA_W'(8 * w), rand_bits(64));
        end
        repeat (count) begin
            wr    = 1'(rand_bits(1));
            f3    = 3'(rand_bits(3));
            a     = BA_W'(rand_bits(6));
            align = rand_bits(2) != 64'd0;
            // mostly legal traffic with the odd fault
            if (align) begin
                a = (a >> f3[1:0]) << f3[1:0];
                if (wr) begin
                    f3[2] = 1'b0;
                end
            end
            issue(wr, f3, a, rand_bits(64));
        end
    endtask

    task automatic start_test();
        errs_start = err_count;
    endtask

    task automatic end_test(input string name);
        // drain the last result through the checks
        idle(2);
        if (err_count == errs_start) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: fail (%0d errors)", name, err_count - errs_start);
        end
    endtask

    initial begin
        repeat (TOTAL_OPS * 4 + 100) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", TOTAL_OPS * 4 + 100);
        $display("sim failed");
        $finish;
    end

    initial begin
        arst_n     = 1'b0;
        req        = 1'b0;
        we         = 1'b0;
        funct3     = 3'b000;
        addr       = '0;
        wdata      = '0;
        next_valid = 1'b0;
        next_fault = 1'b0;
        next_rdata = '0;

        // a legal load and then a misaligned one are held during reset
        // neither may reach rvalid or fault
        start_test();
        req    = 1'b1;
        funct3 = F3_LD;
        repeat (2) @(posedge clk);
        @(negedge clk);
        addr = BA_W'(1);
        @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        req    = 1'b0;
        addr   = '0;
        end_test("reset");

        // word 1 by a double store and word 2 by narrow stores
        start_test();
        issue(1'b1, F3_SD, BA_W'(8), 64'hF1E2_D3C4_B5A6_9788);
        load_sweep(BA_W'(8));
        issue(1'b1, F3_SW, BA_W'(16), 64'h0000_0000_8123_4567);
        issue(1'b1, F3_SW, BA_W'(20), 64'hFFFF_FFFF_7654_C321);
        issue(1'b1, F3_SH, BA_W'(22), 64'h0000_0000_0000_9ABC);
        issue(1'b1, F3_SB, BA_W'(17), 64'h0000_0000_0000_00E7);
        load_sweep(BA_W'(16));
        end_test("sizes");

        // narrow stores keep the neighbour bytes
        start_test();
        issue(1'b1, F3_SD, BA_W'(24), 64'h0123_4567_89AB_CDEF);
        issue(1'b1, F3_SB, BA_W'(27), 64'hFFFF_FFFF_FFFF_FF5A);
        issue(1'b0, F3_LD, BA_W'(24), 64'd0);
        issue(1'b1, F3_SH, BA_W'(28), 64'h1111_2222_3333_BEEF);
        issue(1'b0, F3_LD, BA_W'(24), 64'd0);
        issue(1'b1, F3_SW, BA_W'(28), 64'hAAAA_AAAA_C0DE_F00D);
        issue(1'b0, F3_LD, BA_W'(24), 64'd0);
        end_test("byte_mask");

        // misaligned loads and stores
        start_test();
        issue(1'b1, F3_SD, BA_W'(32), 64'h5566_7788_99AA_BBCC);
        issue(1'b0, F3_LH, BA_W'(33), 64'd0);
        issue(1'b0, F3_LW, BA_W'(34), 64'd0);
        issue(1'b0, F3_LD, BA_W'(36), 64'd0);
        issue(1'b1, F3_SH, BA_W'(35), 64'hFFFF_FFFF_FFFF_FFFF);
        issue(1'b1, F3_SW, BA_W'(38), 64'hFFFF_FFFF_FFFF_FFFF);
        issue(1'b1, F3_SD, BA_W'(33), 64'hFFFF_FFFF_FFFF_FFFF);
        issue(1'b0, F3_LD, BA_W'(32), 64'd0);
        end_test("misaligned");

        // load 111 and stores with bit 2 set
        start_test();
        issue(1'b1, F3_SD, BA_W'(40), 64'hDEAD_BEEF_0BAD_F00D);
        issue(1'b0, 3'b111, BA_W'(40), 64'd0);
        issue(1'b1, 3'b100, BA_W'(40), 64'd0);
        issue(1'b1, 3'b101, BA_W'(40), 64'd0);
        issue(1'b1, 3'b110, BA_W'(40), 64'd0);
        issue(1'b1, 3'b111, BA_W'(40), 64'd0);
        issue(1'b0, F3_LD, BA_W'(40), 64'd0);
        end_test("illegal");

        start_test();
        random_traffic(RANDOM_OPS);
        end_test("random");

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sources.f
design/lsu_pkg.sv
design/lsu_decode.sv
design/lsu_ram.sv
design/lsu_result.sv
design/lsu_top.sv
verification/lsu_tb.sv

// File: Makefile
VERILATOR   = verilator
TOP         = lsu_tb
FILELIST    = sources.f
OBJ_DIR     = obj_dir
BUILD_FLAGS = --binary --timing --assert
LINT_FLAGS  = --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the testbench prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
